// File: logic/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// panel timing, all counts in clk cycles

// wait after reset or re-init before the first byte
`define LCD_POWERUP_CYCLES 500

// e low with rs/data stable before the pulse
`define LCD_E_SETUP_CYCLES 1

// e high width
`define LCD_E_HIGH_CYCLES 13

// start to done for an ordinary command
`define LCD_CMD_CYCLES 50

// start to done for clear display and return home
`define LCD_CLEAR_CYCLES 200

// command queue entries, power of two
`define LCD_FIFO_DEPTH 8

`endif

// File: logic/lcd_cmd_pkg.sv
`default_nettype none

package lcd_cmd_pkg;

	// one byte for the panel bus
	typedef struct packed {
		logic rs; // 0 instruction, 1 character
		logic [7:0] data;
	} lcd_cmd_t;

	// power-up init steps, in issue order
	typedef enum logic [1:0] {
		FUNCTION_SET,
		DISPLAY_CTRL,
		CLEAR,
		ENTRY_MODE
	} lcd_op_e;

	// display configuration, msb first
	typedef struct packed {
		logic lines;      // 1 = two lines
		logic font;       // 1 = 5x10 dots
		logic display_on;
		logic cursor;
		logic blink;
		logic inc_dec;    // 1 = address increments
		logic shift;      // shift display on write
	} lcd_cfg_t;

	typedef enum logic [2:0] {
		POWER_UP,
		INIT,
		IDLE,
		ISSUE,
		WAIT
	} seq_state_e;

endpackage

`default_nettype wire

// File: logic/wb_regs_pkg.sv
`default_nettype none

package wb_regs_pkg;

	// word addresses on the Wishbone side
	typedef enum logic [1:0] {
		CFG    = 2'd0, // read/write, restarts init
		CMD    = 2'd1, // write only, instruction byte
		DATA   = 2'd2, // write only, character byte
		STATUS = 2'd3  // read only
	} reg_addr_e;

	// STATUS read layout, bits 6:0
	typedef struct packed {
		logic init_done;
		logic busy;
		logic fifo_full;
		logic [3:0] fifo_count;
	} status_t;

endpackage

`default_nettype wire

// File: logic/wb_lcd_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module wb_lcd_regs (
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [1:0] adr,
	input wire [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic ack,
	output logic push,
	output lcd_cmd_pkg::lcd_cmd_t push_cmd,
	input wire full,
	input wire [$clog2(`LCD_FIFO_DEPTH):0] fifo_count,
	output lcd_cmd_pkg::lcd_cfg_t cfg,
	output logic reinit,
	input wire init_done,
	input wire busy
);

	// two lines, display on, cursor moves right
	localparam lcd_cmd_pkg::lcd_cfg_t CFG_RESET = '{
		lines: 1'b1, font: 1'b0, display_on: 1'b1, cursor: 1'b0,
		blink: 1'b0, inc_dec: 1'b1, shift: 1'b0
	};

	wb_regs_pkg::reg_addr_e addr;
	wb_regs_pkg::status_t status;
	logic req;      // new cycle, not yet acked
	logic queue_wr; // CMD or DATA write
	logic cfg_wr;

	assign addr = wb_regs_pkg::reg_addr_e'(adr);
	assign req = cyc && stb && !ack;
	assign queue_wr = we && (addr == wb_regs_pkg::CMD || addr == wb_regs_pkg::DATA);
	assign cfg_wr = we && addr == wb_regs_pkg::CFG;

	always_comb begin
		status.init_done = init_done;
		status.busy = busy;
		status.fifo_full = full;
		status.fifo_count = fifo_count;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			push <= 1'b0;
			reinit <= 1'b0;
			cfg <= CFG_RESET;
		end else begin
			ack <= req && (!queue_wr || !full); // hold off while queue full
			push <= req && queue_wr && !full;
			reinit <= req && cfg_wr;
			if (req && cfg_wr)
				cfg <= lcd_cmd_pkg::lcd_cfg_t'(dat_w[6:0]);
		end
	end

	// read data and queue payload
	always_ff @(posedge clk) begin
		if (req) begin
			push_cmd.rs <= (addr == wb_regs_pkg::DATA);
			push_cmd.data <= dat_w[7:0];
			case (addr)
				wb_regs_pkg::CFG: dat_r <= {25'd0, cfg};
				wb_regs_pkg::STATUS: dat_r <= {25'd0, status};
				default: dat_r <= 32'd0; // write-only targets read as zero
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/lcd_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_cmd_fifo (
	input wire clk,
	input wire reset,
	input wire flush,
	input wire push,
	input wire lcd_cmd_pkg::lcd_cmd_t push_cmd,
	output logic full,
	output logic [$clog2(`LCD_FIFO_DEPTH):0] count,
	output logic empty,
	input wire pop,
	output lcd_cmd_pkg::lcd_cmd_t pop_cmd
);

	localparam int AW = $clog2(`LCD_FIFO_DEPTH);

	lcd_cmd_pkg::lcd_cmd_t mem [`LCD_FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == (AW + 1)'(`LCD_FIFO_DEPTH));
	assign empty = (count == '0);
	assign pop_cmd = mem[rd_ptr]; // head shown while not empty

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_cmd;
	end

endmodule

`default_nettype wire

// File: logic/lcd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_sequencer (
	input wire clk,
	input wire reset,
	input wire lcd_cmd_pkg::lcd_cfg_t cfg,
	input wire reinit,
	input wire empty,
	input wire lcd_cmd_pkg::lcd_cmd_t pop_cmd,
	output logic pop,
	output logic start,
	output lcd_cmd_pkg::lcd_cmd_t cmd,
	output logic long_wait,
	input wire done,
	output logic init_done,
	output logic busy
);

	localparam int PW = $clog2(`LCD_POWERUP_CYCLES);

	lcd_cmd_pkg::seq_state_e state;
	lcd_cmd_pkg::lcd_op_e step;
	logic [PW-1:0] pu_cnt;
	lcd_cmd_pkg::lcd_cmd_t init_cmd;

	// init bytes built from the current config
	always_comb begin
		init_cmd.rs = 1'b0;
		case (step)
			lcd_cmd_pkg::FUNCTION_SET:
				init_cmd.data = {4'b0011, cfg.lines, cfg.font, 2'b00};
			lcd_cmd_pkg::DISPLAY_CTRL:
				init_cmd.data = {5'b00001, cfg.display_on, cfg.cursor, cfg.blink};
			lcd_cmd_pkg::CLEAR:
				init_cmd.data = 8'b0000_0001;
			default:
				init_cmd.data = {6'b000001, cfg.inc_dec, cfg.shift};
		endcase
	end

	assign start = (state == lcd_cmd_pkg::INIT) || (state == lcd_cmd_pkg::ISSUE);
	assign pop = (state == lcd_cmd_pkg::ISSUE); // head leaves with its start
	assign cmd = (state == lcd_cmd_pkg::INIT) ? init_cmd : pop_cmd;

	// clear is 0000_0001, return home is 0000_001x
	assign long_wait = !cmd.rs && cmd.data[7:2] == 6'd0 && cmd.data[1:0] != 2'd0;

	assign busy = (state != lcd_cmd_pkg::IDLE) || !empty;

	always_ff @(posedge clk) begin
		if (reset || reinit) begin
			state <= lcd_cmd_pkg::POWER_UP;
			step <= lcd_cmd_pkg::FUNCTION_SET;
			pu_cnt <= '0;
			init_done <= 1'b0;
		end else begin
			case (state)
				lcd_cmd_pkg::POWER_UP: begin
					if (pu_cnt == PW'(`LCD_POWERUP_CYCLES - 1))
						state <= lcd_cmd_pkg::INIT;
					else
						pu_cnt <= pu_cnt + 1'b1;
				end
				lcd_cmd_pkg::INIT: begin
					state <= lcd_cmd_pkg::WAIT;
				end
				lcd_cmd_pkg::IDLE: begin
					if (!empty)
						state <= lcd_cmd_pkg::ISSUE;
				end
				lcd_cmd_pkg::ISSUE: begin
					state <= lcd_cmd_pkg::WAIT;
				end
				lcd_cmd_pkg::WAIT: begin
					if (done) begin
						if (!init_done && step != lcd_cmd_pkg::ENTRY_MODE) begin
							step <= lcd_cmd_pkg::lcd_op_e'(step + 2'd1); // next init byte
							state <= lcd_cmd_pkg::INIT;
						end else begin
							init_done <= 1'b1;
							// back to back when more is queued
							state <= empty ? lcd_cmd_pkg::IDLE : lcd_cmd_pkg::ISSUE;
						end
					end
				end
				default: begin
					state <= lcd_cmd_pkg::POWER_UP;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/lcd_bus_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_bus_timer (
	input wire clk,
	input wire reset,
	input wire start,
	input wire lcd_cmd_pkg::lcd_cmd_t cmd,
	input wire long_wait,
	output logic done,
	output logic e,
	output logic rs,
	output logic [7:0] data
);

	localparam int CW = $clog2(`LCD_CLEAR_CYCLES + 1);

	logic running;
	logic [CW-1:0] cnt;      // cycles since start, 1 on the first
	logic [CW-1:0] cnt_next;
	logic [CW-1:0] last_cnt; // total for this command
	logic pulse_on;

	assign cnt_next = running ? cnt + 1'b1 : {{(CW - 1){1'b0}}, 1'b1};

	// e high after setup, for the high width
	assign pulse_on = cnt_next > CW'(`LCD_E_SETUP_CYCLES) &&
		cnt_next <= CW'(`LCD_E_SETUP_CYCLES + `LCD_E_HIGH_CYCLES);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
			e <= 1'b0;
			rs <= 1'b0;
			data <= 8'd0;
		end else if (!running) begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				cnt <= cnt_next;
				e <= pulse_on;
				rs <= cmd.rs;
				data <= cmd.data;
			end
		end else if (cnt == last_cnt) begin
			// settle time over, release the bus
			running <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
			e <= 1'b0;
			rs <= 1'b0;
			data <= 8'd0;
		end else begin
			cnt <= cnt_next;
			e <= pulse_on;
			done <= (cnt_next == last_cnt); // high on the last cycle
		end
	end

	// start ignored while running
	always_ff @(posedge clk) begin
		if (start && !running)
			last_cnt <= long_wait ? CW'(`LCD_CLEAR_CYCLES) : CW'(`LCD_CMD_CYCLES);
	end

endmodule

`default_nettype wire

// File: logic/lcd_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_ctrl_top (
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [1:0] adr,
	input wire [31:0] dat_w,
	output logic [31:0] dat_r,
	output logic ack,
	output logic e,
	output logic rs,
	output logic [7:0] data
);

	lcd_cmd_pkg::lcd_cmd_t push_cmd;
	lcd_cmd_pkg::lcd_cmd_t pop_cmd;
	lcd_cmd_pkg::lcd_cmd_t cmd;
	lcd_cmd_pkg::lcd_cfg_t cfg;
	logic [$clog2(`LCD_FIFO_DEPTH):0] fifo_count;
	logic push;
	logic full;
	logic empty;
	logic pop;
	logic reinit; // also flushes the queue
	logic init_done;
	logic busy;
	logic start;
	logic long_wait;
	logic done;

	wb_lcd_regs i_regs (
		.clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack), .push(push), .push_cmd(push_cmd),
		.full(full), .fifo_count(fifo_count), .cfg(cfg), .reinit(reinit),
		.init_done(init_done), .busy(busy)
	);

	lcd_cmd_fifo i_fifo (
		.clk(clk), .reset(reset), .flush(reinit), .push(push), .push_cmd(push_cmd),
		.full(full), .count(fifo_count), .empty(empty), .pop(pop), .pop_cmd(pop_cmd)
	);

	lcd_sequencer i_seq (
		.clk(clk), .reset(reset), .cfg(cfg), .reinit(reinit), .empty(empty),
		.pop_cmd(pop_cmd), .pop(pop), .start(start), .cmd(cmd), .long_wait(long_wait),
		.done(done), .init_done(init_done), .busy(busy)
	);

	lcd_bus_timer i_timer (
		.clk(clk), .reset(reset), .start(start), .cmd(cmd), .long_wait(long_wait),
		.done(done), .e(e), .rs(rs), .data(data)
	);

endmodule

`default_nettype wire

// File: sim/lcd_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcd_ctrl_tb;

	typedef enum logic [1:0] {
		OP_WR,
		OP_RD,
		OP_DRAIN,  // wait for the panel bytes, then compare
		OP_STALLS  // some queue writes were held off
	} op_e;

	typedef struct packed {
		logic [2:0] test;
		op_e op;
		wb_regs_pkg::reg_addr_e adr;
		logic [31:0] val;   // write data or expected read bits
		logic [31:0] mask;
		logic drop;         // byte flushed before it reaches the panel
		logic [1:0] gap;    // idle cycles before the row
	} row_t;

	localparam logic [6:0] CFG_AT_RESET = 7'b101_0010; // two lines, display on, increment
	localparam logic [31:0] ST_INIT_DONE = 32'h40;
	localparam logic [31:0] ST_BUSY = 32'h20;
	localparam logic [31:0] ST_FULL = 32'h10;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [1:0] adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic ack;
	logic e;
	logic rs;
	logic [7:0] data;

	row_t rows[$];
	logic [8:0] exp_bytes[$]; // {rs, data}
	logic [8:0] obs_bytes[$];
	string test_name[1:6];
	bit table_ready;
	int errors;
	int test_errors;
	int stalled;
	int cyc_cnt;
	int quiet_from;
	bit quiet_armed;
	int last_rise;
	int high_cnt;
	logic e_prev;
	logic long_prev;

	lcd_ctrl_top i_dut (
		.clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack), .e(e), .rs(rs), .data(data)
	);

	always #20 clk = ~clk;

	task automatic check(input logic [31:0] got, input logic [31:0] want, input string msg);
		if (got !== want) begin
			$display("ERROR at %0t: %s (got %h, expected %h)", $time, msg, got, want);
			errors++;
			test_errors++;
		end
	endtask

	// panel bus monitor, sampled away from the driving edge
	always @(negedge clk) begin
		if (e && !e_prev) begin
			if (quiet_armed) begin
				check(32'(cyc_cnt - quiet_from >= `LCD_POWERUP_CYCLES), 32'd1,
					"e pulse before the power-up wait ended");
				quiet_armed = 1'b0;
			end
			if (long_prev)
				check(32'(cyc_cnt - last_rise >= `LCD_CLEAR_CYCLES), 32'd1,
					"e rose too soon after a clear or home byte");
			last_rise = cyc_cnt;
			high_cnt = 0;
		end
		if (e)
			high_cnt++;
		if (!e && e_prev) begin
			check(32'(high_cnt), `LCD_E_HIGH_CYCLES, "e high width");
			obs_bytes.push_back({rs, data});
			// clear display is 01, return home is 02 or 03
			long_prev = !rs && (data == 8'h01 || data[7:1] == 7'h01);
		end
		e_prev = e;
		cyc_cnt++;
	end

	// the four init bytes, bit layout of the HD44780 command set
	task automatic expect_init(input lcd_cmd_pkg::lcd_cfg_t c);
		exp_bytes.push_back({1'b0, 4'b0011, c.lines, c.font, 2'b00});
		exp_bytes.push_back({1'b0, 5'b00001, c.display_on, c.cursor, c.blink});
		exp_bytes.push_back({1'b0, 8'b0000_0001});
		exp_bytes.push_back({1'b0, 6'b000001, c.inc_dec, c.shift});
	endtask

	task automatic wb_cycle(input logic write, input wb_regs_pkg::reg_addr_e a,
		input logic [31:0] wdata, output logic [31:0] rdata, output int waits);
		waits = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= a;
		dat_w <= wdata;
		do begin
			@(negedge clk);
			waits++;
		end while (!ack);
		rdata = dat_r;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic add_row(input logic [2:0] test, input op_e op,
		input wb_regs_pkg::reg_addr_e a, input logic [31:0] val, input logic [31:0] mask,
		input logic drop, input logic [1:0] gap);
		row_t r;
		r.test = test;
		r.op = op;
		r.adr = a;
		r.val = val;
		r.mask = mask;
		r.drop = drop;
		r.gap = gap;
		rows.push_back(r);
	endtask

	task automatic build_table();
		test_name[1] = "power-up init with reset config";
		test_name[2] = "reconfigure flushes queued bytes";
		test_name[3] = "character and instruction order";
		test_name[4] = "burst past queue depth";
		test_name[5] = "enable width and clear settle time";
		test_name[6] = "busy follows pending bytes";
		add_row(1, OP_DRAIN, wb_regs_pkg::CFG, 0, 0, 0, 0);
		add_row(1, OP_RD, wb_regs_pkg::STATUS, ST_INIT_DONE, ST_INIT_DONE | ST_BUSY, 0, 0);
		add_row(1, OP_RD, wb_regs_pkg::CFG, {25'd0, CFG_AT_RESET}, 32'h7f, 0, 0);
		add_row(2, OP_WR, wb_regs_pkg::DATA, 32'h41, 0, 0, 0); // already in flight
		add_row(2, OP_WR, wb_regs_pkg::DATA, 32'h42, 0, 1, 0);
		add_row(2, OP_WR, wb_regs_pkg::DATA, 32'h43, 0, 1, 0);
		add_row(2, OP_WR, wb_regs_pkg::CFG, 32'h3d, 0, 0, 0);
		add_row(2, OP_RD, wb_regs_pkg::STATUS, 32'h00, ST_INIT_DONE | 32'h0f, 0, 0);
		add_row(2, OP_DRAIN, wb_regs_pkg::CFG, 0, 0, 0, 0);
		add_row(2, OP_RD, wb_regs_pkg::CFG, 32'h3d, 32'h7f, 0, 0);
		add_row(3, OP_WR, wb_regs_pkg::DATA, 32'h48, 0, 0, 0);
		add_row(3, OP_WR, wb_regs_pkg::CMD, 32'h80, 0, 0, 0);
		add_row(3, OP_WR, wb_regs_pkg::DATA, 32'h69, 0, 0, 0);
		add_row(3, OP_WR, wb_regs_pkg::CMD, 32'h02, 0, 0, 0); // return home
		add_row(3, OP_WR, wb_regs_pkg::DATA, 32'h21, 0, 0, 0);
		add_row(3, OP_DRAIN, wb_regs_pkg::CFG, 0, 0, 0, 0);
		add_row(3, OP_RD, wb_regs_pkg::STATUS, ST_INIT_DONE, 32'h7f, 0, 0);
		for (int i = 0; i < 14; i++)
			add_row(4, OP_WR, wb_regs_pkg::DATA, {24'd0, 8'($urandom)}, 0, 0,
				2'($urandom % 2));
		add_row(4, OP_RD, wb_regs_pkg::STATUS, ST_BUSY | ST_FULL, ST_BUSY | ST_FULL, 0, 0);
		for (int i = 0; i < 10; i++)
			add_row(4, OP_WR, wb_regs_pkg::DATA, {24'd0, 8'($urandom)}, 0, 0,
				2'($urandom % 2));
		add_row(4, OP_STALLS, wb_regs_pkg::CFG, 0, 0, 0, 0);
		add_row(4, OP_DRAIN, wb_regs_pkg::CFG, 0, 0, 0, 0);
		add_row(4, OP_RD, wb_regs_pkg::STATUS, ST_INIT_DONE, 32'h7f, 0, 0);
		add_row(5, OP_WR, wb_regs_pkg::CMD, 32'h01, 0, 0, 0); // clear display
		add_row(5, OP_WR, wb_regs_pkg::DATA, 32'h2a, 0, 0, 0);
		add_row(5, OP_WR, wb_regs_pkg::CMD, 32'h03, 0, 0, 0);
		add_row(5, OP_WR, wb_regs_pkg::DATA, 32'h2b, 0, 0, 0);
		add_row(5, OP_DRAIN, wb_regs_pkg::CFG, 0, 0, 0, 0);
		add_row(6, OP_WR, wb_regs_pkg::DATA, 32'h55, 0, 0, 0);
		add_row(6, OP_RD, wb_regs_pkg::STATUS, ST_INIT_DONE | ST_BUSY, ST_INIT_DONE | ST_BUSY,
			0, 0);
		add_row(6, OP_DRAIN, wb_regs_pkg::CFG, 0, 0, 0, 0);
		add_row(6, OP_RD, wb_regs_pkg::STATUS, ST_INIT_DONE, ST_INIT_DONE | ST_BUSY, 0, 0);
	endtask

	task automatic run_row(input row_t r);
		logic [31:0] rd;
		int waits;
		int n;
		repeat (r.gap) @(posedge clk);
		case (r.op)
			OP_WR: begin
				wb_cycle(1'b1, r.adr, r.val, rd, waits);
				if (r.adr == wb_regs_pkg::CFG) begin
					expect_init(lcd_cmd_pkg::lcd_cfg_t'(r.val[6:0]));
					quiet_from = cyc_cnt; // init restarts with a fresh wait
					quiet_armed = 1'b1;
				end else if (r.adr == wb_regs_pkg::CMD || r.adr == wb_regs_pkg::DATA) begin
					if (!r.drop)
						exp_bytes.push_back({r.adr == wb_regs_pkg::DATA, r.val[7:0]});
					if (waits > 2)
						stalled++; // ack held back by a full queue
				end
			end
			OP_RD: begin
				wb_cycle(1'b0, r.adr, 32'd0, rd, waits);
				check(rd & r.mask, r.val & r.mask, $sformatf("read of register %0d", r.adr));
			end
			OP_DRAIN: begin
				while (obs_bytes.size() < exp_bytes.size())
					@(posedge clk);
				repeat (`LCD_CLEAR_CYCLES) @(posedge clk); // last command settles
				check(32'(obs_bytes.size()), 32'(exp_bytes.size()), "number of panel bytes");
				n = (obs_bytes.size() < exp_bytes.size()) ? obs_bytes.size() : exp_bytes.size();
				for (int i = 0; i < n; i++)
					check(32'(obs_bytes[i]), 32'(exp_bytes[i]), $sformatf("panel byte %0d", i));
				obs_bytes.delete();
				exp_bytes.delete();
			end
			default: begin
				check(32'(stalled > 0), 32'd1, "no write was held off while the queue was full");
				stalled = 0;
			end
		endcase
	endtask

	initial begin
		int tests_run;
		int tests_failed;
		void'($urandom(32'hafe1_c5bb));
		clk = 1'b0;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 2'd0;
		dat_w = 32'd0;
		e_prev = 1'b0;
		long_prev = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		build_table();
		table_ready = 1'b1;
		expect_init(lcd_cmd_pkg::lcd_cfg_t'(CFG_AT_RESET));
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		quiet_from = cyc_cnt;
		quiet_armed = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			run_row(rows[i]);
			if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
				tests_run++;
				if (test_errors == 0) begin
					$display("test %0d, %s: ok", rows[i].test, test_name[rows[i].test]);
				end else begin
					tests_failed++;
					$display("test %0d, %s: %0d errors", rows[i].test,
						test_name[rows[i].test], test_errors);
				end
				test_errors = 0;
			end
		end
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// bounded by the worst case of every row waiting on a clear
	initial begin
		int limit;
		wait (table_ready);
		limit = rows.size() * `LCD_CLEAR_CYCLES * 4 + `LCD_POWERUP_CYCLES;
		repeat (limit) @(posedge clk);
		$display("timeout: the run did not finish within %0d clock cycles", limit);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: lcd_ctrl_top.f
+incdir+logic
logic/lcd_cmd_pkg.sv
logic/wb_regs_pkg.sv
logic/wb_lcd_regs.sv
logic/lcd_cmd_fifo.sv
logic/lcd_sequencer.sv
logic/lcd_bus_timer.sv
logic/lcd_ctrl_top.sv
sim/lcd_ctrl_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --timescale 1ns/1ps
TOP = lcd_ctrl_tb
FILELIST = lcd_ctrl_top.f
OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# grep decides the result from the simulator output
run: compile
	set -o pipefail 2>/dev/null; ./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
